// File: verilog/instPkg.sv
`default_nettype none

package instPkg;

   // one instruction word as it enters the queue
   typedef logic [11:0] instWord_t;

   // opcode field position inside instWord_t
   localparam int OpcodeHigh = 11;
   localparam int OpcodeLow  = 8;

   // read of button n is opReadBtn0 + n
   typedef enum logic [3:0] {
      opNop      = 4'd0,
      opReadAll  = 4'd1,
      opReadBtn0 = 4'd2
   } opcode_t;

endpackage

`default_nettype wire

// File: verilog/bankPkg.sv
`default_nettype none

package bankPkg;

   typedef enum logic [1:0] {
      stResetting = 2'd0,
      stReady     = 2'd1,
      stError     = 2'd2
   } bankState_t;

   // opcodes 2..15 address buttons 0..13
   localparam int MaxButtons = 14;

   localparam int DebounceWidth = 16;

endpackage

`default_nettype wire

// File: verilog/buttonConditioner.sv
`timescale 1ns/1ps
`default_nettype none

module buttonConditioner #(
   parameter int NumButtons     = 4,
   parameter int DebounceCycles = 8
) (
   input  logic                  clock,
   input  logic                  reset,
   input  logic [NumButtons-1:0] buttonsRaw,
   output logic [NumButtons-1:0] cleanButtons
);

   import bankPkg::*;

   // counter value on the cycle the clean level flips
   localparam logic [DebounceWidth-1:0] FlipCount = DebounceWidth'(DebounceCycles - 1);

   logic [NumButtons-1:0]    syncFirst;
   logic [NumButtons-1:0]    syncSecond;
   logic [DebounceWidth-1:0] stableCount [NumButtons];

   // two-stage synchronizer
   always_ff @(posedge clock) begin
      if (reset) begin
         syncFirst  <= '0;
         syncSecond <= '0;
      end else begin
         syncFirst  <= buttonsRaw;
         syncSecond <= syncFirst;
      end
   end

   // each button counts how long its synced level disagrees with the clean one
   always_ff @(posedge clock) begin
      if (reset) begin
         cleanButtons <= '0;
         for (int i = 0; i < NumButtons; i++) begin
            stableCount[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NumButtons; i++) begin
            if (syncSecond[i] != cleanButtons[i]) begin
               if (stableCount[i] == FlipCount) begin
                  cleanButtons[i] <= syncSecond[i];   // stable long enough
                  stableCount[i]  <= '0;
               end else begin
                  stableCount[i] <= stableCount[i] + 1'b1;
               end
            end else begin
               stableCount[i] <= '0;                  // bounce restarts the count
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/instQueue.sv
`timescale 1ns/1ps
`default_nettype none

module instQueue #(
   parameter int QueueDepth = 4
) (
   input  logic               clock,
   input  logic               reset,
   input  instPkg::instWord_t inst,
   input  logic               instEn,
   output instPkg::instWord_t headInst,
   output logic               headValid,
   input  logic               instTake,
   output logic               instDropped
);

   import instPkg::*;

   localparam int AddrWidth = $clog2(QueueDepth);
   localparam logic [AddrWidth:0] FullCount = (AddrWidth + 1)'(QueueDepth);

   instWord_t            storage [QueueDepth];
   logic [AddrWidth-1:0] writePtr;
   logic [AddrWidth-1:0] readPtr;
   logic [AddrWidth:0]   occupancy;
   logic                 full;
   logic                 doPush;
   logic                 doPop;

   assign full      = (occupancy == FullCount);
   assign headValid = (occupancy != '0);
   assign headInst  = storage[readPtr];

   assign doPop  = instTake && headValid;
   assign doPush = instEn && (!full || doPop);   // a pop frees the slot on the same edge

   always_ff @(posedge clock) begin
      if (doPush) begin
         storage[writePtr] <= inst;
      end
   end

   // pointers wrap naturally since depth is a power of two
   always_ff @(posedge clock) begin
      if (reset) begin
         writePtr    <= '0;
         readPtr     <= '0;
         occupancy   <= '0;
         instDropped <= 1'b0;
      end else begin
         if (doPush) begin
            writePtr <= writePtr + 1'b1;
         end
         if (doPop) begin
            readPtr <= readPtr + 1'b1;
         end
         case ({doPush, doPop})
            2'b10:   occupancy <= occupancy + 1'b1;
            2'b01:   occupancy <= occupancy - 1'b1;
            default: occupancy <= occupancy;
         endcase
         instDropped <= instEn && !doPush;   // refused write
      end
   end

endmodule

`default_nettype wire

// File: verilog/pushBtnBank.sv
`timescale 1ns/1ps
`default_nettype none

module pushBtnBank #(
   parameter int NumButtons = 4
) (
   input  logic                  clock,
   input  logic                  reset,
   input  logic [NumButtons-1:0] cleanButtons,
   input  instPkg::instWord_t    headInst,
   input  logic                  headValid,
   input  logic                  pause,
   output logic                  instTake,
   output logic [NumButtons-1:0] btnState,
   output logic                  error
);

   import instPkg::*;
   import bankPkg::*;

   // reads beyond this count are illegal
   localparam int LegalButtons = (NumButtons < MaxButtons) ? NumButtons : MaxButtons;

   bankState_t            state;
   bankState_t            stateNext;
   logic [NumButtons-1:0] pending;
   logic [NumButtons-1:0] pendingNext;
   logic [NumButtons-1:0] btnNext;
   opcode_t               opcode;
   int                    readIdx;

   assign opcode  = opcode_t'(headInst[OpcodeHigh:OpcodeLow]);
   assign readIdx = int'(opcode) - int'(opReadBtn0);

   assign instTake = (state == stReady) && !pause && headValid;
   assign error    = (state == stError);

   always_comb begin
      stateNext   = state;
      pendingNext = pending | cleanButtons;   // presses stick until read
      btnNext     = btnState;
      case (state)
         stResetting: begin
            stateNext   = stReady;
            pendingNext = '0;
            btnNext     = '0;
         end
         stReady: begin
            if (instTake) begin
               case (opcode)
                  opNop: begin
                     stateNext = stReady;   // latching only
                  end
                  opReadAll: begin
                     btnNext     = pending;
                     pendingNext = cleanButtons;
                  end
                  default: begin
                     if (readIdx < LegalButtons) begin
                        btnNext[readIdx]     = pending[readIdx];
                        pendingNext[readIdx] = cleanButtons[readIdx];
                     end else begin
                        stateNext   = stError;   // unknown opcode or missing button
                        pendingNext = '0;
                        btnNext     = '0;
                     end
                  end
               endcase
            end
         end
         default: begin
            // sticky until reset
            stateNext   = stError;
            pendingNext = '0;
            btnNext     = '0;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state    <= stResetting;
         pending  <= '0;
         btnState <= '0;
      end else begin
         state    <= stateNext;
         pending  <= pendingNext;
         btnState <= btnNext;
      end
   end

endmodule

`default_nettype wire

// File: verilog/pushBtnSystem.sv
`timescale 1ns/1ps
`default_nettype none

module pushBtnSystem #(
   parameter int NumButtons     = 4,
   parameter int DebounceCycles = 8,
   parameter int QueueDepth     = 4
) (
   input  logic                  clock,
   input  logic                  reset,
   input  logic [NumButtons-1:0] buttonsRaw,
   input  instPkg::instWord_t    inst,
   input  logic                  instEn,
   input  logic                  pause,
   output logic [NumButtons-1:0] btnState,
   output logic                  error,
   output logic                  instDropped
);

   import instPkg::*;

   logic [NumButtons-1:0] cleanButtons;
   instWord_t             headInst;
   logic                  headValid;
   logic                  instTake;

   buttonConditioner #(
      .NumButtons     (NumButtons),
      .DebounceCycles (DebounceCycles)
   ) i_buttonConditioner (
      .clock        (clock),
      .reset        (reset),
      .buttonsRaw   (buttonsRaw),
      .cleanButtons (cleanButtons)
   );

   instQueue #(
      .QueueDepth (QueueDepth)
   ) i_instQueue (
      .clock       (clock),
      .reset       (reset),
      .inst        (inst),
      .instEn      (instEn),
      .headInst    (headInst),
      .headValid   (headValid),
      .instTake    (instTake),
      .instDropped (instDropped)
   );

   // bank alone decides when the head is consumed
   pushBtnBank #(
      .NumButtons (NumButtons)
   ) i_pushBtnBank (
      .clock        (clock),
      .reset        (reset),
      .cleanButtons (cleanButtons),
      .headInst     (headInst),
      .headValid    (headValid),
      .pause        (pause),
      .instTake     (instTake),
      .btnState     (btnState),
      .error        (error)
   );

endmodule

`default_nettype wire

// File: sim/pushBtnSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module pushBtnSystemTb;

   import instPkg::*;
   import bankPkg::*;

   localparam int NumButtons     = 4;
   localparam int DebounceCycles = 8;
   localparam int QueueDepth     = 4;
   localparam int Seed           = 65;

   // phase lengths in clock cycles
   localparam int ResetCycles    = 10;
   localparam int IdleCycles     = 30;
   localparam int Segments       = 30;
   localparam int MaxHold        = 60;
   localparam int SettleCycles   = DebounceCycles + 6;
   localparam int ReadGap        = 3;
   localparam int DirectedCycles = 2 * (2 * SettleCycles + (NumButtons + 2) * (ReadGap + 1));
   localparam int DropExtra      = 3;
   localparam int BurstLen       = QueueDepth + DropExtra;
   localparam int DrainCycles    = 2 * QueueDepth + 8;
   localparam int BurstCycles    = QueueDepth + 2 + BurstLen + 1 + DrainCycles;
   localparam int ErrorRounds    = 2;
   localparam int ErrorHold      = 40;
   localparam int RecoverCycles  = 40;
   localparam int ErrorCycles    = ErrorRounds *
                                   (QueueDepth + 3 + ErrorHold + ResetCycles + 1 + RecoverCycles);
   localparam int CycleLimit     = ResetCycles + IdleCycles + Segments * MaxHold +
                                   DirectedCycles + BurstCycles + ErrorCycles + 100;

   logic                  clock;
   logic                  reset;
   logic [NumButtons-1:0] buttonsRaw;
   instWord_t             inst;
   logic                  instEn;
   logic                  pause;
   logic [NumButtons-1:0] btnState;
   logic                  error;
   logic                  instDropped;

   // reference model state
   logic [NumButtons-1:0] mSync1;
   logic [NumButtons-1:0] mSync2;
   logic [NumButtons-1:0] mClean;
   logic [NumButtons-1:0] mPending;
   logic [NumButtons-1:0] mBtn;
   logic [NumButtons-1:0] nextPending;
   logic [NumButtons-1:0] nextBtn;
   int                    mCount [NumButtons];
   bankState_t            mState;
   instWord_t             mQueue [$];
   instWord_t             mHead;
   logic                  mDropped;
   logic                  mTake;
   int                    mOp;
   logic                  modelLive;
   int                    cycleCount;

   logic [NumButtons-1:0] level;
   logic [NumButtons-1:0] raw;
   logic [NumButtons-1:0] glitchMask;
   logic [NumButtons-1:0] pattern;
   int                    hold;
   int                    glitchLen;
   int                    illegalOp;
   int unsigned           seedValue;

   pushBtnSystem #(
      .NumButtons     (NumButtons),
      .DebounceCycles (DebounceCycles),
      .QueueDepth     (QueueDepth)
   ) i_pushBtnSystem (
      .clock       (clock),
      .reset       (reset),
      .buttonsRaw  (buttonsRaw),
      .inst        (inst),
      .instEn      (instEn),
      .pause       (pause),
      .btnState    (btnState),
      .error       (error),
      .instDropped (instDropped)
   );

   always #4 clock = ~clock;

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkState(input string name, input logic [NumButtons-1:0] got,
                             input logic [NumButtons-1:0] expected);
      if (got !== expected) begin
         abortRun($sformatf("[FAIL] %0d ns: %s is %b, expected %b", $time, name, got, expected));
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic expected);
      if (got !== expected) begin
         abortRun($sformatf("[FAIL] %0d ns: %s is %b, expected %b", $time, name, got, expected));
      end
   endtask

   function automatic instWord_t randomLegalInst();
      logic [3:0] op;
      logic [7:0] spare;
      op    = 4'($urandom % (NumButtons + 2));
      spare = 8'($urandom);
      return {op, spare};
   endfunction

   // one cycle of stimulus, applied on the falling edge
   task automatic stepCycle(input logic [NumButtons-1:0] rawLevel, input logic en,
                            input instWord_t word, input logic holdOff);
      @(negedge clock);
      buttonsRaw = rawLevel;
      instEn     = en;
      inst       = word;
      pause      = holdOff;
   endtask

   task automatic idleCycles(input logic [NumButtons-1:0] rawLevel, input int count);
      repeat (count) stepCycle(rawLevel, 1'b0, '0, 1'b0);
   endtask

   task automatic issueAndWait(input logic [NumButtons-1:0] rawLevel, input instWord_t word);
      stepCycle(rawLevel, 1'b1, word, 1'b0);
      idleCycles(rawLevel, ReadGap);
   endtask

   task automatic applyReset();
      @(negedge clock);
      reset      = 1'b1;
      buttonsRaw = '0;
      instEn     = 1'b0;
      inst       = '0;
      pause      = 1'b0;
      repeat (ResetCycles) @(negedge clock);
      reset = 1'b0;
   endtask

   // read-all twice, then single reads after the buttons flip
   task automatic directedReads(input logic [NumButtons-1:0] buttons);
      logic [NumButtons-1:0] expectState;
      idleCycles(buttons, SettleCycles);
      issueAndWait(buttons, {opReadAll, 8'h00});
      issueAndWait(buttons, {opReadAll, 8'h00});
      checkState("btnState after read-all", btnState, buttons);
      idleCycles(~buttons, SettleCycles);
      expectState = buttons;
      for (int n = 0; n < NumButtons; n++) begin
         expectState[n] = 1'b1;   // latch saw both levels, one of them high
         issueAndWait(~buttons, {4'(n + 2), 8'h00});
         checkState("btnState after single read", btnState, expectState);
      end
   endtask

   // cycle model, stepped on every rising edge
   always @(posedge clock) begin
      if (reset) begin
         mSync1   = '0;
         mSync2   = '0;
         mClean   = '0;
         mPending = '0;
         mBtn     = '0;
         mState   = stResetting;
         mDropped = 1'b0;
         mQueue.delete();
         for (int i = 0; i < NumButtons; i++) begin
            mCount[i] = 0;
         end
      end else begin
         mTake       = (mState == stReady) && !pause && (mQueue.size() != 0);
         nextPending = mPending;
         nextBtn     = mBtn;
         if (mState == stResetting) begin
            mState      = stReady;
            nextPending = '0;
            nextBtn     = '0;
         end else if (mState == stReady) begin
            nextPending = mPending | mClean;
            if (mTake) begin
               mHead = mQueue.pop_front();
               mOp   = int'(mHead[11:8]);
               if (mOp == 1) begin
                  nextBtn     = mPending;
                  nextPending = mClean;
               end else if (mOp >= 2 && mOp < 2 + NumButtons) begin
                  nextBtn[mOp-2]     = mPending[mOp-2];
                  nextPending[mOp-2] = mClean[mOp-2];
               end else if (mOp != 0) begin
                  mState      = stError;
                  nextPending = '0;
                  nextBtn     = '0;
               end
            end
         end else begin
            nextPending = '0;
            nextBtn     = '0;
         end
         mPending = nextPending;
         mBtn     = nextBtn;
         mDropped = 1'b0;
         if (instEn) begin
            if (mQueue.size() < QueueDepth) begin
               mQueue.push_back(inst);   // pop above already freed a slot
            end else begin
               mDropped = 1'b1;
            end
         end
         for (int i = 0; i < NumButtons; i++) begin
            if (mSync2[i] != mClean[i]) begin
               mCount[i]++;
               if (mCount[i] == DebounceCycles) begin
                  mClean[i] = mSync2[i];
                  mCount[i] = 0;
               end
            end else begin
               mCount[i] = 0;
            end
         end
         mSync2 = mSync1;
         mSync1 = buttonsRaw;
      end
      modelLive = 1'b1;
   end

   always @(negedge clock) begin
      if (modelLive) begin
         checkState("btnState", btnState, mBtn);
         checkFlag("error", error, mState == stError);
         checkFlag("instDropped", instDropped, mDropped);
      end
   end

   always @(posedge clock) begin
      cycleCount++;
      if (cycleCount >= CycleLimit) begin
         abortRun($sformatf("timeout: the tests did not finish within %0d cycles", CycleLimit));
      end
   end

   initial begin
      clock      = 1'b0;
      reset      = 1'b1;
      buttonsRaw = '0;
      inst       = '0;
      instEn     = 1'b0;
      pause      = 1'b0;
      modelLive  = 1'b0;
      cycleCount = 0;
      seedValue  = $urandom(Seed);
      repeat (ResetCycles) @(negedge clock);
      reset = 1'b0;

      idleCycles('0, IdleCycles);
      checkState("btnState when idle", btnState, '0);
      checkFlag("error when idle", error, 1'b0);
      checkFlag("instDropped when idle", instDropped, 1'b0);

      // random levels with short glitches and random legal reads
      for (int s = 0; s < Segments; s++) begin
         level      = NumButtons'($urandom);
         hold       = 20 + int'($urandom % 41);
         glitchLen  = 1 + int'($urandom % (DebounceCycles - 1));
         glitchMask = '0;
         if ($urandom % 2 == 1) begin
            glitchMask[$urandom % NumButtons] = 1'b1;
         end
         for (int c = 0; c < hold; c++) begin
            raw = level;
            if (c >= hold / 2 && c < hold / 2 + glitchLen) begin
               raw = level ^ glitchMask;   // too short to debounce
            end
            stepCycle(raw, $urandom % 4 == 0, randomLegalInst(), $urandom % 8 == 0);
         end
      end

      pattern = NumButtons'($urandom);
      directedReads(pattern);
      directedReads(~pattern);

      // fill the queue while paused
      level = NumButtons'($urandom);
      idleCycles(level, QueueDepth + 2);
      for (int i = 0; i < BurstLen; i++) begin
         stepCycle(level, 1'b1, randomLegalInst(), 1'b1);
         if (i > 0) begin
            checkFlag("instDropped in burst", instDropped, (i - 1) >= QueueDepth);
         end
      end
      stepCycle(level, 1'b0, '0, 1'b1);
      checkFlag("instDropped in burst", instDropped, 1'b1);
      idleCycles(level, DrainCycles);

      for (int r = 0; r < ErrorRounds; r++) begin
         level     = NumButtons'($urandom);
         illegalOp = 2 + NumButtons + int'($urandom % (MaxButtons - NumButtons));
         idleCycles(level, QueueDepth + 2);
         stepCycle(level, 1'b1, {4'(illegalOp), 8'($urandom)}, 1'b0);
         for (int c = 0; c < ErrorHold; c++) begin
            stepCycle(NumButtons'($urandom), $urandom % 2 == 0, randomLegalInst(), 1'b0);
            if (c >= 2) begin
               checkFlag("error after illegal opcode", error, 1'b1);
               checkState("btnState in error", btnState, '0);
            end
         end
         applyReset();
         checkFlag("error after reset", error, 1'b0);
         for (int c = 0; c < RecoverCycles; c++) begin
            if (c % 20 == 0) begin
               level = NumButtons'($urandom);
            end
            stepCycle(level, $urandom % 4 == 0, randomLegalInst(), 1'b0);
         end
         checkFlag("error after recovery", error, 1'b0);
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: pushBtnSystem.f
verilog/instPkg.sv
verilog/bankPkg.sv
verilog/buttonConditioner.sv
verilog/instQueue.sv
verilog/pushBtnBank.sv
verilog/pushBtnSystem.sv
sim/pushBtnSystemTb.sv

// File: Makefile
# Verilator build and run for the push-button peripheral
# override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
SIM_TOP   ?= pushBtnSystemTb
FILELIST  ?= pushBtnSystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
EXTRA     ?=

.PHONY: sim clean

# the simulator exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(SIM_TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(SIM_TOP)

clean:
	rm -rf $(BUILD_DIR)
